// ==== byte_packer.sv ====
`timescale 1ns/1ns
`include "stream_settings.svh"

module byte_packer
  import stream_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      buf_valid,
  output logic                      buf_ready,
  input  logic [`STREAM_BYTE_W-1:0] buf_data,
  output logic                      out_valid,
  input  logic                      out_ready,
  output logic [`STREAM_WORD_W-1:0] out_word
);

  pack_state_e               state;
  logic [`STREAM_BYTE_W-1:0] low_byte;  // earlier byte of the pair
  logic                      buf_fire;
  logic                      word_done;

  // word register free or leaving this cycle
  assign buf_ready = !out_valid || out_ready;
  assign buf_fire  = buf_valid && buf_ready;
  assign word_done = buf_fire && state == pk_high;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= pk_low;
    end else if (buf_fire) begin
      case (state)
        pk_low:  state <= pk_high;
        pk_high: state <= pk_low;
        default: state <= pk_low;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (buf_fire && state == pk_low) begin
      low_byte <= buf_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (word_done) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // high byte goes in the upper half
  always_ff @(posedge clk) begin
    if (word_done) begin
      out_word <= {buf_data, low_byte};
    end
  end

endmodule

// ==== compile.f ====
+incdir+.
stream_pkg.sv
stream_alu_stage.sv
skid_buf.sv
byte_packer.sv
stream_top.sv
stream_tb.sv

// ==== skid_buf.sv ====
`timescale 1ns/1ns
`include "stream_settings.svh"

module skid_buf #(
  parameter int OUT_REG = 1  // 1 puts a register stage on the output side
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      s_valid,
  output logic                      s_ready,
  input  logic [`STREAM_BYTE_W-1:0] s_data,
  output logic                      m_valid,
  input  logic                      m_ready,
  output logic [`STREAM_BYTE_W-1:0] m_data
);

  logic                      skid_valid;  // skid entry occupied
  logic [`STREAM_BYTE_W-1:0] skid_data;
  logic                      s_fire;
  logic                      out_stall;   // main entry cannot take the incoming byte

  // ready is the inverse of a flop, so it never depends on s_valid
  assign s_ready = !skid_valid;
  assign s_fire  = s_valid && s_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      skid_valid <= 1'b0;
    end else if (s_fire && out_stall) begin
      skid_valid <= 1'b1;  // byte was in flight when the consumer stopped
    end else if (m_ready) begin
      skid_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (s_fire) begin
      skid_data <= s_data;
    end
  end

  if (OUT_REG != 0) begin : g_out_reg
    logic                      main_valid;
    logic [`STREAM_BYTE_W-1:0] main_data;
    logic                      main_load;

    assign main_load = !main_valid || m_ready;
    assign out_stall = main_valid && !m_ready;

    always_ff @(posedge clk) begin
      if (!rst_n) begin
        main_valid <= 1'b0;
      end else if (main_load) begin
        main_valid <= s_valid || skid_valid;
      end
    end

    // skid entry is older, so it goes out first
    always_ff @(posedge clk) begin
      if (main_load) begin
        main_data <= skid_valid ? skid_data : s_data;
      end
    end

    assign m_valid = main_valid;
    assign m_data  = main_data;
  end else begin : g_no_reg
    // main entry is the input itself, seen in the same cycle
    assign out_stall = !m_ready;
    assign m_valid   = s_valid || skid_valid;
    assign m_data    = skid_valid ? skid_data : s_data;
  end

endmodule

// ==== stream_alu_stage.sv ====
`timescale 1ns/1ns
`include "stream_settings.svh"

module stream_alu_stage
  import stream_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      in_valid,
  output logic                      in_ready,
  input  stream_op_e                in_op,
  input  logic [`STREAM_BYTE_W-1:0] in_data,
  output logic                      alu_valid,
  input  logic                      alu_ready,
  output logic [`STREAM_BYTE_W-1:0] alu_data
);

  localparam int HALF_W = `STREAM_BYTE_W / 2;

  logic                      in_fire;
  logic [`STREAM_BYTE_W-1:0] acc;       // running sum, only op_sum touches it
  logic [`STREAM_BYTE_W-1:0] sum;
  logic [`STREAM_BYTE_W-1:0] result;

  // output register can take a new byte when empty or draining this cycle
  assign in_ready = !alu_valid || alu_ready;
  assign in_fire  = in_valid && in_ready;

  assign sum = acc + in_data;  // wraps modulo 256

  always_comb begin
    case (in_op)
      op_pass:   result = in_data;
      op_invert: result = ~in_data;
      op_swap:   result = {in_data[HALF_W-1:0], in_data[`STREAM_BYTE_W-1:HALF_W]};
      op_sum:    result = sum;
      default:   result = in_data;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      alu_valid <= 1'b0;
    end else if (in_fire) begin
      alu_valid <= 1'b1;
    end else if (alu_ready) begin
      alu_valid <= 1'b0;  // result taken, nothing new behind it
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      alu_data <= result;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acc <= '0;
    end else if (in_fire && in_op == op_sum) begin
      acc <= sum;
    end
  end

endmodule

// ==== stream_pkg.sv ====
`include "stream_settings.svh"

package stream_pkg;

  // per-byte operation selected at the stream input
  typedef enum logic [`STREAM_OP_W-1:0] {
    op_pass,    // unchanged
    op_invert,  // bitwise not
    op_swap,    // nibble swap
    op_sum      // running sum with accumulator
  } stream_op_e;

  // packer pairing state
  typedef enum logic {
    pk_low,     // next byte is the low half
    pk_high     // low half held, waiting for the high half
  } pack_state_e;

endpackage

// ==== stream_settings.svh ====
`ifndef STREAM_SETTINGS_SVH
`define STREAM_SETTINGS_SVH

// data byte carried through every stage
`define STREAM_BYTE_W 8

// packed output word, two bytes with the earlier one in the low half
`define STREAM_WORD_W 16

// opcode field that travels next to each input byte
`define STREAM_OP_W 2

`endif

// ==== stream_tb.sv ====
`timescale 1ns/1ns
`include "stream_settings.svh"

module stream_tb
  import stream_pkg::*;
();

  logic                      clk;
  logic                      rst_n;
  logic                      in_valid;
  logic                      in_ready;
  stream_op_e                in_op;
  logic [`STREAM_BYTE_W-1:0] in_data;
  logic                      out_valid;
  logic                      out_ready;
  logic [`STREAM_WORD_W-1:0] out_word;

  logic [31:0]               rng_state;
  logic [`STREAM_BYTE_W-1:0] model_acc;
  logic                      model_have_low;  // model holds the low byte of a pair
  logic [`STREAM_BYTE_W-1:0] model_low;
  logic [`STREAM_WORD_W-1:0] exp_words[$];
  int                        words_seen;

  stream_top dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_op     (in_op),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_word  (out_word)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // reference behavior of one byte, pairs land in exp_words low byte first
  function automatic void model_byte(input stream_op_e op, input logic [7:0] d);
    logic [7:0] r;
    case (op)
      op_pass:   r = d;
      op_invert: r = ~d;
      op_swap:   r = {d[3:0], d[7:4]};
      default: begin
        r = model_acc + d;
        model_acc = r;
      end
    endcase
    if (model_have_low) begin
      exp_words.push_back({r, model_low});
      model_have_low = 1'b0;
    end else begin
      model_low = r;
      model_have_low = 1'b1;
    end
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic drive_byte(input stream_op_e op, input logic [7:0] d);
    model_byte(op, d);
    in_valid <= 1'b1;
    in_op    <= op;
    in_data  <= d;
  endtask

  task automatic wait_accept();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!in_ready) begin
      cycles++;
      if (cycles > 200) begin
        report_failure("timeout: in_ready stayed low while a byte was offered");
      end
      @(negedge clk);
    end
    @(posedge clk);  // transfer edge
    in_valid <= 1'b0;
  endtask

  task automatic send_byte(input stream_op_e op, input logic [7:0] d);
    drive_byte(op, d);
    wait_accept();
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_words.size() != 0) begin
      @(posedge clk);
      cycles++;
      if (cycles > 500) begin
        report_failure("timeout: expected words never came out of the DUT");
      end
    end
  endtask

  // word monitor, sampled mid-cycle where the handshake is stable
  initial begin
    words_seen = 0;
    forever begin
      @(negedge clk);
      if (rst_n && out_valid && out_ready) begin
        if (exp_words.size() == 0) begin
          report_failure("a word came out of the DUT while none was expected");
        end else begin
          check_value("out_word", out_word, exp_words.pop_front());
          words_seen++;
        end
      end
    end
  end

  task automatic opcode_test();
    send_byte(op_pass, 8'h12);
    send_byte(op_pass, 8'h34);    // 16'h3412
    send_byte(op_invert, 8'h0f);
    send_byte(op_invert, 8'ha5);
    send_byte(op_swap, 8'h3c);
    send_byte(op_pass, 8'h9e);
    send_byte(op_invert, 8'h00);
    send_byte(op_swap, 8'hd1);
    wait_drain();
  endtask

  task automatic running_sum_test();
    send_byte(op_sum, 8'hc8);     // acc c8
    send_byte(op_sum, 8'h64);     // wraps to 2c
    send_byte(op_pass, 8'h77);
    send_byte(op_sum, 8'h10);     // 3c, pass left acc alone
    send_byte(op_sum, 8'hf0);     // 2c again
    send_byte(op_pass, 8'hff);
    wait_drain();
  endtask

  task automatic backpressure_test();
    int  n;
    logic stalled;
    n = 0;
    stalled = 1'b0;
    out_ready <= 1'b0;
    while (!stalled && n < 16) begin
      drive_byte(op_pass, 8'h40 + n[7:0]);
      n++;
      @(negedge clk);
      if (!in_ready) begin
        stalled = 1'b1;
      end else begin
        @(posedge clk);
      end
    end
    if (!stalled) begin
      report_failure("in_ready never fell while out_ready was held low");
    end
    @(posedge clk);
    out_ready <= 1'b1;
    wait_accept();  // the refused byte goes in once the stall clears
    if (n % 2 != 0) begin
      send_byte(op_invert, 8'h5c);
    end
    wait_drain();
  endtask

  task automatic random_test();
    logic [31:0] r;
    logic        offered;
    int          sent;
    int          cycles;
    sent    = 0;
    cycles  = 0;
    offered = 1'b0;
    while (sent < 200) begin
      r = next_rand();
      if (!offered) begin
        drive_byte(stream_op_e'(r[25:24]), r[23:16]);
        offered = 1'b1;
      end
      out_ready <= r[31] | r[29];  // high about three cycles in four
      @(negedge clk);
      if (in_ready) begin
        sent++;
        offered = 1'b0;
      end
      @(posedge clk);
      cycles++;
      if (cycles > 4000) begin
        report_failure("timeout: random stream did not finish sending");
      end
    end
    in_valid  <= 1'b0;
    out_ready <= 1'b1;
    wait_drain();
  endtask

  task automatic reset_test();
    int cycles;
    send_byte(op_pass, 8'ha5);
    send_byte(op_pass, 8'h5a);
    wait_drain();
    out_ready <= 1'b0;            // word, buffer and stage all end up full
    cycles = 0;
    drive_byte(op_sum, 8'h33);
    @(negedge clk);
    while (in_ready) begin
      cycles++;
      if (cycles > 50) begin
        report_failure("timeout: in_ready never fell before the reset");
      end
      @(posedge clk);
      drive_byte(op_sum, 8'h33 + cycles[7:0]);
      @(negedge clk);
    end
    @(posedge clk);
    rst_n     <= 1'b0;
    in_valid  <= 1'b0;
    out_ready <= 1'b1;
    exp_words.delete();
    model_acc      = '0;
    model_have_low = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("out_valid", out_valid, 0);
    check_value("in_ready", in_ready, 1);
    @(posedge clk);
    send_byte(op_sum, 8'h21);     // acc restarts at 0, expect 16'h3321
    send_byte(op_sum, 8'h12);
    wait_drain();
  endtask

  initial begin
    rng_state      = 32'hd824_934b;
    model_acc      = '0;
    model_have_low = 1'b0;
    model_low      = '0;
    rst_n          = 1'b0;
    in_valid       = 1'b0;
    in_op          = op_pass;
    in_data        = '0;
    out_ready      = 1'b1;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    opcode_test();
    running_sum_test();
    backpressure_test();
    random_test();
    reset_test();
    $display("%0d words checked", words_seen);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== stream_top.sv ====
`timescale 1ns/1ns
`include "stream_settings.svh"

module stream_top
  import stream_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      in_valid,
  output logic                      in_ready,
  input  stream_op_e                in_op,
  input  logic [`STREAM_BYTE_W-1:0] in_data,
  output logic                      out_valid,
  input  logic                      out_ready,
  output logic [`STREAM_WORD_W-1:0] out_word
);

  logic                      alu_valid;
  logic                      alu_ready;
  logic [`STREAM_BYTE_W-1:0] alu_data;

  logic                      buf_valid;
  logic                      buf_ready;
  logic [`STREAM_BYTE_W-1:0] buf_data;

  stream_alu_stage u_alu (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_op     (in_op),
    .in_data   (in_data),
    .alu_valid (alu_valid),
    .alu_ready (alu_ready),
    .alu_data  (alu_data)
  );

  // registered output keeps the packer off the stage's timing path
  skid_buf #(
    .OUT_REG (1)
  ) u_skid (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_valid (alu_valid),
    .s_ready (alu_ready),
    .s_data  (alu_data),
    .m_valid (buf_valid),
    .m_ready (buf_ready),
    .m_data  (buf_data)
  );

  byte_packer u_pack (
    .clk       (clk),
    .rst_n     (rst_n),
    .buf_valid (buf_valid),
    .buf_ready (buf_ready),
    .buf_data  (buf_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_word  (out_word)
  );

endmodule
